/* Makefile */
# Verilator build and run for the ball tracker testbench

TOP = image_proc_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f image_proc.f \
		--top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* image_proc.f */
+incdir+testbench
logic/image_proc_pkg.sv
logic/stream_reg.sv
logic/pixel_classifier.sv
logic/box_tracker.sv
logic/overlay_painter.sv
logic/message_writer.sv
logic/register_port.sv
logic/image_proc.sv
testbench/image_proc_tb.sv

/* logic/box_tracker.sv */
// pixel coordinates, packet type and per-colour x bounds
// bounds latched at the end of each video frame
`timescale 1ns/1ps
`default_nettype none

module box_tracker #(
	parameter int IMAGE_W = 640,
	parameter int HORIZON_ROW = 280
) (
	input  logic                         clk,
	input  logic                         reset_n,
	input  image_proc_pkg::pixel_beat_t  beat,
	input  logic                         advance,
	input  image_proc_pkg::colour_mask_t confirmed,
	output image_proc_pkg::coord_t       x,
	output logic                         packet_video,
	output image_proc_pkg::bounds_set_t  boxes,
	output logic                         frame_done
);
	import image_proc_pkg::*;

	// left past right means nothing seen
	localparam bounds_t NOT_FOUND = '{left: coord_t'(IMAGE_W - 1), right: coord_t'(0)};

	coord_t y;
	bounds_set_t run_bounds, run_next;
	logic frame_end;

	assign frame_end = advance && beat.eop && !beat.sop && packet_video;

	// running bounds including the current pixel
	always_comb begin
		run_next = run_bounds;
		if (beat.sop) begin
			run_next = {NUM_COLOURS{NOT_FOUND}};
		end else if (y >= coord_t'(HORIZON_ROW)) begin
			for (int i = 0; i < NUM_COLOURS; i++) begin
				if (confirmed[i] && x < run_next[i].left)
					run_next[i].left = x;
				if (confirmed[i] && x > run_next[i].right)
					run_next[i].right = x;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x <= '0;
			y <= '0;
			packet_video <= 1'b0;
			frame_done <= 1'b0;
			run_bounds <= {NUM_COLOURS{NOT_FOUND}};
			boxes <= {NUM_COLOURS{NOT_FOUND}};
		end else begin
			frame_done <= frame_end;
			if (advance) begin
				run_bounds <= run_next;
				// sop is the packet descriptor, first pixel follows at 0,0
				if (beat.sop) begin
					x <= '0;
					y <= '0;
					packet_video <= (beat.rgb.blue[3:0] == 4'h0);
				end else if (x == coord_t'(IMAGE_W - 1)) begin
					x <= '0;
					y <= y + 1'b1;
				end else begin
					x <= x + 1'b1;
				end
			end
			// hold for overlay and messages over the next frame
			if (frame_end)
				boxes <= run_next;
		end
	end

	a_x_range: assert property (@(posedge clk) disable iff (!reset_n) x < coord_t'(IMAGE_W))
		else $error("box_tracker x out of image");

endmodule

`default_nettype wire

/* logic/image_proc.sv */
// ball tracker top: stream registers, classifier, tracker,
// overlay, message buffer and register port
`timescale 1ns/1ps
`default_nettype none

module image_proc #(
	parameter int IMAGE_W = 640,
	parameter int HORIZON_ROW = 280,
	parameter int RUN_LEN = 4,
	parameter int MSG_INTERVAL = 6
) (
	input  logic        clk,
	input  logic        reset_n,
	// mm slave
	input  logic        s_chipselect,
	input  logic        s_read,
	input  logic        s_write,
	input  logic [2:0]  s_address,
	input  logic [31:0] s_writedata,
	output logic [31:0] s_readdata,
	// stream sink
	input  logic [23:0] sink_data,
	input  logic        sink_valid,
	output logic        sink_ready,
	input  logic        sink_sop,
	input  logic        sink_eop,
	// stream source
	output logic [23:0] source_data,
	output logic        source_valid,
	input  logic        source_ready,
	output logic        source_sop,
	output logic        source_eop,
	input  logic        mode
);
	import image_proc_pkg::*;

	pixel_beat_t sink_beat, cur_beat, painted, source_beat;
	logic cur_valid, cur_ready, advance;
	colour_mask_t confirmed;
	coord_t x;
	logic packet_video, frame_done, pop, flush;
	bounds_set_t boxes;
	logic [7:0] msg_count;
	msg_word_t head_word;

	assign sink_beat = {sink_data, sink_sop, sink_eop};
	assign {source_data, source_sop, source_eop} = source_beat;
	// current beat moves on into the output register
	assign advance = cur_valid && cur_ready;

	//////////////////////////////////////////////////
	// stream path
	//////////////////////////////////////////////////
	stream_reg u_in_reg (
		.clk(clk), .reset_n(reset_n),
		.in_valid(sink_valid), .in_ready(sink_ready), .in_beat(sink_beat),
		.out_valid(cur_valid), .out_ready(cur_ready), .out_beat(cur_beat)
	);

	stream_reg u_out_reg (
		.clk(clk), .reset_n(reset_n),
		.in_valid(cur_valid), .in_ready(cur_ready), .in_beat(painted),
		.out_valid(source_valid), .out_ready(source_ready), .out_beat(source_beat)
	);

	pixel_classifier #(.RUN_LEN(RUN_LEN)) u_classifier (
		.clk(clk), .reset_n(reset_n), .pixel(cur_beat.rgb),
		.advance(advance), .confirmed(confirmed)
	);

	box_tracker #(.IMAGE_W(IMAGE_W), .HORIZON_ROW(HORIZON_ROW)) u_tracker (
		.clk(clk), .reset_n(reset_n), .beat(cur_beat), .advance(advance),
		.confirmed(confirmed), .x(x), .packet_video(packet_video),
		.boxes(boxes), .frame_done(frame_done)
	);

	overlay_painter u_painter (
		.beat(cur_beat), .mode(mode), .packet_video(packet_video), .x(x),
		.boxes(boxes), .confirmed(confirmed), .painted(painted)
	);

	//////////////////////////////////////////////////
	// cpu side
	//////////////////////////////////////////////////
	message_writer #(.MSG_INTERVAL(MSG_INTERVAL)) u_msg (
		.clk(clk), .reset_n(reset_n), .frame_done(frame_done), .boxes(boxes),
		.pop(pop), .flush(flush), .msg_count(msg_count), .head_word(head_word)
	);

	register_port u_regs (
		.clk(clk), .reset_n(reset_n),
		.s_chipselect(s_chipselect), .s_read(s_read), .s_write(s_write),
		.s_address(s_address), .s_writedata(s_writedata), .s_readdata(s_readdata),
		.msg_count(msg_count), .head_word(head_word), .pop(pop), .flush(flush)
	);

endmodule

`default_nettype wire

/* logic/image_proc_pkg.sv */
// shared widths, pixel and colour types, paint codes, hsv thresholds
// register map and message constants for the ball tracker
`default_nettype none

package image_proc_pkg;

	localparam int NUM_COLOURS = 4;
	localparam int MSG_WORDS = 5;
	localparam int MSG_BUF_DEPTH = 32;

	typedef logic [10:0] coord_t;
	typedef logic [31:0] msg_word_t;
	// one bit per ball colour, bit 0 is red
	typedef logic [NUM_COLOURS-1:0] colour_mask_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	typedef struct packed {
		rgb_t rgb;
		logic sop;
		logic eop;
	} pixel_beat_t;

	// colour numbers as sent in message words
	typedef enum logic [2:0] {
		COL_NONE,
		COL_RED,
		COL_YELLOW,
		COL_TEAL,
		COL_BLUE
	} colour_e;

	typedef struct packed {
		coord_t left;
		coord_t right;
	} bounds_t;

	typedef bounds_t [NUM_COLOURS-1:0] bounds_set_t;

	// hue in half degrees, wrap_lo opens a second window up to 180
	typedef struct packed {
		logic [7:0] hue_lo;
		logic [7:0] hue_hi;
		logic [7:0] wrap_lo;
		logic [7:0] sat_min;
		logic [7:0] val_min;
	} thresh_t;

	localparam thresh_t THRESH [NUM_COLOURS] = '{
		'{8'd0, 8'd6, 8'd172, 8'd100, 8'd100},
		'{8'd16, 8'd30, 8'd255, 8'd100, 8'd100},
		'{8'd60, 8'd85, 8'd255, 8'd100, 8'd100},
		'{8'd97, 8'd125, 8'd255, 8'd100, 8'd100}
	};

	localparam rgb_t COLOUR_CODE [NUM_COLOURS] = '{24'hff1000, 24'hffff00, 24'h008080, 24'h00008b};
	localparam rgb_t BOX_CODE [NUM_COLOURS] = '{24'hff0000, 24'hffff00, 24'h008080, 24'h0000ab};

	// register map
	localparam logic [2:0] REG_STATUS = 3'd0;
	localparam logic [2:0] REG_MSG = 3'd1;
	localparam logic [2:0] REG_ID = 3'd2;
	localparam logic [31:0] DEVICE_ID = 32'h1234EEE2;

	localparam msg_word_t MSG_HEADER = {8'h00, "BBX"};

endpackage

`default_nettype wire

/* logic/message_writer.sv */
// frame interval counter, bounding-box word sequencer
// and circular message buffer read by the cpu
`timescale 1ns/1ps
`default_nettype none

module message_writer #(
	parameter int MSG_INTERVAL = 6
) (
	input  logic                        clk,
	input  logic                        reset_n,
	input  logic                        frame_done,
	input  image_proc_pkg::bounds_set_t boxes,
	input  logic                        pop,
	input  logic                        flush,
	output logic [7:0]                  msg_count,
	output image_proc_pkg::msg_word_t   head_word
);
	import image_proc_pkg::*;

	localparam int PTR_W = $clog2(MSG_BUF_DEPTH);
	localparam int CNT_W = $clog2(MSG_INTERVAL + 1);

	logic [CNT_W-1:0] frame_cnt;
	// 0 idle, 1 header, 2..5 red to blue
	logic [2:0] seq;
	colour_e word_col;
	logic start, wr_en, rd_en;
	msg_word_t wr_word;
	msg_word_t msg_mem [MSG_BUF_DEPTH];
	logic [PTR_W-1:0] rd_ptr, wr_ptr;
	logic [PTR_W:0] count;

	assign start = frame_done && frame_cnt == '0 && seq == 3'd0 &&
		int'(count) <= MSG_BUF_DEPTH - MSG_WORDS;
	assign rd_en = pop && count != '0;
	assign word_col = colour_e'(seq - 3'd1);

	//////////////////////////////////////////////////
	// interval and sequencer
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			frame_cnt <= '0;
			seq <= 3'd0;
		end else begin
			if (start)
				frame_cnt <= CNT_W'(MSG_INTERVAL - 1);
			else if (frame_done && frame_cnt != '0)
				frame_cnt <= frame_cnt - 1'b1;
			if (start)
				seq <= 3'd1;
			else if (seq == 3'(MSG_WORDS))
				seq <= 3'd0;
			else if (seq != 3'd0)
				seq <= seq + 3'd1;
		end
	end

	// colour word layout: number, left at 26..16, right at 10..0
	always_comb begin
		wr_en = (seq != 3'd0);
		wr_word = MSG_HEADER;
		if (seq > 3'd1)
			wr_word = {4'(word_col), 1'b0, boxes[seq - 3'd2].left, 5'b0, boxes[seq - 3'd2].right};
	end

	//////////////////////////////////////////////////
	// buffer
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (wr_en)
			msg_mem[wr_ptr] <= wr_word;
	end

	always_ff @(posedge clk) begin
		if (!reset_n || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (PTR_W+1)'(wr_en) - (PTR_W+1)'(rd_en);
		end
	end

	assign msg_count = 8'(count);
	assign head_word = msg_mem[rd_ptr];

	// the start check must leave room for the whole message
	a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
		wr_en |-> int'(count) < MSG_BUF_DEPTH)
		else $error("message_writer write into full buffer");

endmodule

`default_nettype wire

/* logic/overlay_painter.sv */
// output pixel select: box column, confirmed colour, grey or original
`timescale 1ns/1ps
`default_nettype none

module overlay_painter (
	input  image_proc_pkg::pixel_beat_t  beat,
	input  logic                         mode,
	input  logic                         packet_video,
	input  image_proc_pkg::coord_t       x,
	input  image_proc_pkg::bounds_set_t  boxes,
	input  image_proc_pkg::colour_mask_t confirmed,
	output image_proc_pkg::pixel_beat_t  painted
);
	import image_proc_pkg::*;

	logic [7:0] grey;

	// g/2 + r/4 + b/4
	assign grey = {1'b0, beat.rgb.green[7:1]} + {2'b0, beat.rgb.red[7:2]} +
		{2'b0, beat.rgb.blue[7:2]};

	always_comb begin : paint
		rgb_t art;
		art = '{grey, grey, grey};
		// walk down so the lowest colour number wins
		for (int i = NUM_COLOURS - 1; i >= 0; i--) begin
			if (confirmed[i])
				art = COLOUR_CODE[i];
		end
		// box columns over everything, only for found colours
		for (int i = NUM_COLOURS - 1; i >= 0; i--) begin
			if (boxes[i].left <= boxes[i].right && (x == boxes[i].left || x == boxes[i].right))
				art = BOX_CODE[i];
		end
		painted = beat;
		// descriptor beat and non-video packets untouched
		if (mode && packet_video && !beat.sop)
			painted.rgb = art;
	end

endmodule

`default_nettype wire

/* logic/pixel_classifier.sv */
// rgb to hsv conversion, per colour threshold windows
// and run-length confirmation of detections
`timescale 1ns/1ps
`default_nettype none

module pixel_classifier #(
	parameter int RUN_LEN = 4
) (
	input  logic                         clk,
	input  logic                         reset_n,
	input  image_proc_pkg::rgb_t         pixel,
	input  logic                         advance,
	output image_proc_pkg::colour_mask_t confirmed
);
	import image_proc_pkg::*;

	localparam int HIST_W = RUN_LEN - 1;

	logic [7:0] value, min_c, delta, sat, hue;
	int hue_num;
	colour_mask_t detect;
	// previous detections per colour, newest in bit 0
	logic [HIST_W-1:0] hist [NUM_COLOURS];

	//////////////////////////////////////////////////
	// hexcone hsv
	//////////////////////////////////////////////////
	assign value = (pixel.red > pixel.green) ?
		((pixel.red > pixel.blue) ? pixel.red : pixel.blue) :
		((pixel.green > pixel.blue) ? pixel.green : pixel.blue);
	assign min_c = (pixel.red < pixel.green) ?
		((pixel.red < pixel.blue) ? pixel.red : pixel.blue) :
		((pixel.green < pixel.blue) ? pixel.green : pixel.blue);
	assign delta = value - min_c;
	assign sat = (value == 8'd0) ? 8'd0 : 8'((16'(delta) * 16'd255) / 16'(value));

	// grey pixels get hue 0
	always_comb begin
		hue_num = 0;
		if (delta != 8'd0) begin
			if (value != pixel.red) begin
				// blue max
				if (value != pixel.green)
					hue_num = 240 * int'(delta) + 60 * (int'(pixel.red) - int'(pixel.green));
				// green max
				else
					hue_num = 120 * int'(delta) + 60 * (int'(pixel.blue) - int'(pixel.red));
			end else if (pixel.blue < pixel.green) begin
				hue_num = 60 * (int'(pixel.green) - int'(pixel.blue));
			end else begin
				hue_num = 360 * int'(delta) + 60 * (int'(pixel.green) - int'(pixel.blue));
			end
			hue_num = hue_num / int'(delta);
		end
		// degrees to half degrees
		hue = 8'(hue_num >> 1);
	end

	//////////////////////////////////////////////////
	// thresholds and run filter
	//////////////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < NUM_COLOURS; i++) begin
			detect[i] = ((hue >= THRESH[i].hue_lo && hue <= THRESH[i].hue_hi) ||
				hue >= THRESH[i].wrap_lo) &&
				sat >= THRESH[i].sat_min && value >= THRESH[i].val_min;
			confirmed[i] = detect[i] && (&hist[i]);
		end
	end

	// history moves only with the stream
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < NUM_COLOURS; i++)
				hist[i] <= '0;
		end else if (advance) begin
			for (int i = 0; i < NUM_COLOURS; i++)
				hist[i] <= HIST_W'({hist[i], detect[i]});
		end
	end

endmodule

`default_nettype wire

/* logic/register_port.sv */
// memory-mapped slave: status, message read with pop, id, flush
`timescale 1ns/1ps
`default_nettype none

module register_port (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      s_chipselect,
	input  logic                      s_read,
	input  logic                      s_write,
	input  logic [2:0]                s_address,
	input  logic [31:0]               s_writedata,
	output logic [31:0]               s_readdata,
	input  logic [7:0]                msg_count,
	input  image_proc_pkg::msg_word_t head_word,
	output logic                      pop,
	output logic                      flush
);
	import image_proc_pkg::*;

	localparam int FLUSH_BIT = 4;

	logic rd_sel, read_d;

	assign rd_sel = s_chipselect && s_read;
	// one pop per read, on its first cycle
	assign pop = rd_sel && !read_d && s_address == REG_MSG && msg_count != 8'd0;
	assign flush = s_chipselect && s_write && s_address == REG_STATUS && s_writedata[FLUSH_BIT];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			s_readdata <= '0;
			read_d <= 1'b0;
		end else begin
			read_d <= rd_sel;
			if (rd_sel) begin
				case (s_address)
					REG_STATUS: s_readdata <= {16'h0, msg_count, 8'h0};
					REG_MSG:    s_readdata <= head_word;
					REG_ID:     s_readdata <= DEVICE_ID;
					default:    s_readdata <= '0;
				endcase
			end
		end
	end

	// a held read takes only one word
	a_pop_once: assert property (@(posedge clk) disable iff (!reset_n)
		pop |=> !pop)
		else $error("register_port popped twice within one read");

endmodule

`default_nettype wire

/* logic/stream_reg.sv */
// single-entry ready/valid register stage for pixel beats
`timescale 1ns/1ps
`default_nettype none

module stream_reg (
	input  logic                        clk,
	input  logic                        reset_n,
	input  logic                        in_valid,
	output logic                        in_ready,
	input  image_proc_pkg::pixel_beat_t in_beat,
	output logic                        out_valid,
	input  logic                        out_ready,
	output image_proc_pkg::pixel_beat_t out_beat
);

	// low for the first cycle out of reset
	logic live;

	// take a beat when empty or when the held one leaves
	assign in_ready = live && (!out_valid || out_ready);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			live <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			live <= 1'b1;
			if (in_ready)
				out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_ready && in_valid)
			out_beat <= in_beat;
	end

	// a stalled beat must not change under the consumer
	a_hold_stable: assert property (@(posedge clk) disable iff (!reset_n)
		out_valid && !out_ready |=> out_valid && $stable(out_beat))
		else $error("stream_reg beat changed while stalled");

endmodule

`default_nettype wire

/* testbench/image_proc_tb_model.svh */
// reference model: hsv colour windows, run confirmation, grey,
// overlay choice, bounds and message words
`ifndef IMAGE_PROC_TB_MODEL_SVH
`define IMAGE_PROC_TB_MODEL_SVH

// hue windows in half degrees, red also owns 172..180
localparam int HUE_LO [NUM_COLOURS] = '{0, 16, 60, 97};
localparam int HUE_HI [NUM_COLOURS] = '{6, 30, 85, 125};

// model state, follows the stream beat by beat
int m_run [NUM_COLOURS] = '{default: 0};
int m_lo [NUM_COLOURS] = '{default: IMAGE_W - 1};
int m_hi [NUM_COLOURS] = '{default: 0};
int m_box_lo [NUM_COLOURS] = '{default: IMAGE_W - 1};
int m_box_hi [NUM_COLOURS] = '{default: 0};
int m_x = 0;
int m_y = 0;
int m_gap = 0;
logic m_video = 1'b0;

function automatic colour_mask_t detect_colours(input rgb_t p);
	int r, g, b, mx, mn, sat, hue;
	colour_mask_t m;
	r = p.red;
	g = p.green;
	b = p.blue;
	mx = (r > g) ? r : g;
	mx = (b > mx) ? b : mx;
	mn = (r < g) ? r : g;
	mn = (b < mn) ? b : mn;
	sat = (mx == 0) ? 0 : (mx - mn) * 255 / mx;
	// hexcone hue in degrees, then halved
	if (mx == mn)
		hue = 0;
	else if (mx == r)
		hue = ((60 * (g - b) / (mx - mn) + 360) % 360) / 2;
	else if (mx == g)
		hue = (120 + 60 * (b - r) / (mx - mn)) / 2;
	else
		hue = (240 + 60 * (r - g) / (mx - mn)) / 2;
	for (int i = 0; i < NUM_COLOURS; i++) begin
		m[i] = ((hue >= HUE_LO[i] && hue <= HUE_HI[i]) || (i == 0 && hue >= 172)) &&
			sat >= 100 && mx >= 100;
	end
	return m;
endfunction

function automatic rgb_t grey_of(input rgb_t p);
	int lum;
	lum = int'(p.green) / 2 + int'(p.red) / 4 + int'(p.blue) / 4;
	return {3{8'(lum)}};
endfunction

// latched box of colour i found and sitting on the current column
function automatic logic box_column(input int i);
	logic found;
	found = m_box_lo[i] != IMAGE_W - 1 || m_box_hi[i] != 0;
	return found && (m_x == m_box_lo[i] || m_x == m_box_hi[i]);
endfunction

task automatic model_beat(input pixel_beat_t in, input logic mode_on,
	output pixel_beat_t out);
	colour_mask_t det, conf;
	rgb_t art;
	logic picked;
	det = detect_colours(in.rgb);
	// a run of RUN_LEN detections, this pixel included
	for (int i = 0; i < NUM_COLOURS; i++) begin
		conf[i] = det[i] && m_run[i] >= RUN_LEN - 1;
		m_run[i] = det[i] ? m_run[i] + 1 : 0;
	end
	out = in;
	if (in.sop) begin
		m_x = 0;
		m_y = 0;
		m_video = (in.rgb.blue[3:0] == 4'h0);
		for (int i = 0; i < NUM_COLOURS; i++) begin
			m_lo[i] = IMAGE_W - 1;
			m_hi[i] = 0;
		end
	end else begin
		art = grey_of(in.rgb);
		picked = 1'b0;
		for (int i = 0; i < NUM_COLOURS; i++) begin
			if (!picked && box_column(i)) begin
				art = BOX_CODE[i];
				picked = 1'b1;
			end
		end
		for (int i = 0; i < NUM_COLOURS; i++) begin
			if (!picked && conf[i]) begin
				art = COLOUR_CODE[i];
				picked = 1'b1;
			end
		end
		if (mode_on && m_video)
			out.rgb = art;
		// bounds below the horizon only
		for (int i = 0; i < NUM_COLOURS; i++) begin
			if (conf[i] && m_y >= HORIZON_ROW) begin
				m_lo[i] = (m_x < m_lo[i]) ? m_x : m_lo[i];
				m_hi[i] = (m_x > m_hi[i]) ? m_x : m_hi[i];
			end
		end
		if (in.eop && m_video) begin
			m_box_lo = m_lo;
			m_box_hi = m_hi;
			// header then red to blue
			if (m_gap == 0) begin
				exp_words.push_back(32'h0042_4258);
				for (int i = 0; i < NUM_COLOURS; i++)
					exp_words.push_back(msg_word_t'(((i + 1) << 28) | (m_lo[i] << 16) | m_hi[i]));
				m_gap = MSG_INTERVAL - 1;
			end else begin
				m_gap--;
			end
		end
		m_x++;
		if (m_x == IMAGE_W) begin
			m_x = 0;
			m_y++;
		end
	end
endtask

`endif

/* testbench/image_proc_tb.sv */
// ball tracker testbench: frame table, random back-pressure,
// output beat and message word checks, register port reads
`timescale 1ns/1ps
`default_nettype none

module image_proc_tb;
	import image_proc_pkg::*;

	localparam int IMAGE_W = 16;
	localparam int HORIZON_ROW = 4;
	localparam int RUN_LEN = 3;
	localparam int MSG_INTERVAL = 2;
	localparam int ROWS = 8;
	localparam int NUM_FRAMES = 6;
	localparam int NUM_SEGS = 11;
	// descriptor beat plus one beat per pixel
	localparam int PKT_BEATS = IMAGE_W * ROWS + 1;
	localparam int CYCLE_LIMIT = 4 * NUM_FRAMES * PKT_BEATS + 200;
	localparam rgb_t BACKGROUND = 24'h808080;

	typedef struct packed {
		logic mode;
		logic video;
	} frame_t;

	typedef struct packed {
		logic [2:0] frame;
		logic [2:0] row;
		coord_t x0;
		coord_t x1;
		colour_e col;
	} seg_t;

	//////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////
	// mode, video per packet; frame 2 is a non-video packet
	localparam frame_t FRAMES [NUM_FRAMES] = '{
		'{1'b0, 1'b1}, '{1'b1, 1'b1}, '{1'b1, 1'b0},
		'{1'b1, 1'b1}, '{1'b0, 1'b1}, '{1'b1, 1'b1}
	};

	// frame, row, first x, last x, colour
	localparam seg_t SEGS [NUM_SEGS] = '{
		'{3'd0, 3'd5, 11'd2, 11'd6, COL_RED},
		'{3'd0, 3'd6, 11'd9, 11'd13, COL_BLUE},
		'{3'd0, 3'd1, 11'd3, 11'd8, COL_YELLOW},
		'{3'd1, 3'd4, 11'd0, 11'd5, COL_TEAL},
		'{3'd1, 3'd7, 11'd10, 11'd15, COL_YELLOW},
		'{3'd1, 3'd2, 11'd1, 11'd6, COL_RED},
		'{3'd2, 3'd5, 11'd0, 11'd15, COL_RED},
		'{3'd3, 3'd6, 11'd3, 11'd4, COL_BLUE},
		'{3'd3, 3'd5, 11'd7, 11'd12, COL_RED},
		'{3'd4, 3'd4, 11'd13, 11'd15, COL_TEAL},
		'{3'd5, 3'd7, 11'd0, 11'd15, COL_BLUE}
	};

	logic clk, reset_n, mode;
	logic s_chipselect, s_read, s_write;
	logic [2:0] s_address;
	logic [31:0] s_writedata, s_readdata;
	pixel_beat_t sink_beat;
	logic sink_valid, sink_ready;
	logic [23:0] source_data;
	logic source_valid, source_ready, source_sop, source_eop;

	pixel_beat_t exp_beats [$];
	msg_word_t exp_words [$];
	int cycles;

	image_proc #(
		.IMAGE_W(IMAGE_W), .HORIZON_ROW(HORIZON_ROW),
		.RUN_LEN(RUN_LEN), .MSG_INTERVAL(MSG_INTERVAL)
	) u_dut (
		.clk(clk), .reset_n(reset_n),
		.s_chipselect(s_chipselect), .s_read(s_read), .s_write(s_write),
		.s_address(s_address), .s_writedata(s_writedata), .s_readdata(s_readdata),
		.sink_data(sink_beat.rgb), .sink_valid(sink_valid), .sink_ready(sink_ready),
		.sink_sop(sink_beat.sop), .sink_eop(sink_beat.eop),
		.source_data(source_data), .source_valid(source_valid),
		.source_ready(source_ready), .source_sop(source_sop), .source_eop(source_eop),
		.mode(mode)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// run limit from the table length
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: no end of test after %0d cycles", cycles);
		stop_failed();
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////
	task automatic stop_failed();
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_beat(input pixel_beat_t got, input pixel_beat_t exp);
		if (got !== exp) begin
			$display("Fail source_beat: got %h expected %h", got, exp);
			stop_failed();
		end
	endtask

	task automatic check_word(input string name, input msg_word_t got, input msg_word_t exp);
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			stop_failed();
		end
	endtask

	task automatic check_count(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("Fail msg_count: got %h expected %h", got, exp);
			stop_failed();
		end
	endtask

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////
	// teal window sits on pure green
	function automatic rgb_t pure_colour(input colour_e c);
		case (c)
			COL_RED:    return 24'hff0000;
			COL_YELLOW: return 24'hffff00;
			COL_TEAL:   return 24'h00ff00;
			COL_BLUE:   return 24'h0000ff;
			default:    return BACKGROUND;
		endcase
	endfunction

	function automatic rgb_t pixel_at(input int f, input int px, input int py);
		rgb_t p;
		p = BACKGROUND;
		foreach (SEGS[i]) begin
			if (SEGS[i].frame == f && SEGS[i].row == py && px >= SEGS[i].x0 && px <= SEGS[i].x1)
				p = pure_colour(SEGS[i].col);
		end
		return p;
	endfunction

	// one packet in, all its beats out and checked
	task automatic send_packet(input int f);
		pixel_beat_t beats [$];
		pixel_beat_t beat, exp;
		int sent;
		logic in_fire;
		// descriptor: blue low nibble zero marks video
		beat.rgb = FRAMES[f].video ? 24'h000000 : 24'h000003;
		beat.sop = 1'b1;
		beat.eop = 1'b0;
		beats.push_back(beat);
		for (int y = 0; y < ROWS; y++) begin
			for (int x = 0; x < IMAGE_W; x++) begin
				beat.rgb = pixel_at(f, x, y);
				beat.sop = 1'b0;
				beat.eop = (y == ROWS - 1 && x == IMAGE_W - 1);
				beats.push_back(beat);
			end
		end
		foreach (beats[i]) begin
			model_beat(beats[i], FRAMES[f].mode, exp);
			exp_beats.push_back(exp);
		end
		sent = 0;
		in_fire = 1'b0;
		while (sent < beats.size() || exp_beats.size() != 0) begin
			@(negedge clk);
			if (in_fire)
				sent++;
			mode = FRAMES[f].mode;
			source_ready = ($urandom % 4) != 0;
			sink_valid = sent < beats.size();
			if (sink_valid)
				sink_beat = beats[sent];
			// settle, then these hold until the rising edge
			#1;
			in_fire = sink_valid && sink_ready;
			if (source_valid && source_ready) begin
				if (exp_beats.size() == 0) begin
					$display("output beat appeared with none expected");
					stop_failed();
				end
				check_beat(pixel_beat_t'({source_data, source_sop, source_eop}),
					exp_beats.pop_front());
			end
		end
	endtask

	task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
		@(negedge clk);
		s_chipselect = 1'b1;
		s_read = 1'b1;
		s_address = addr;
		@(negedge clk);
		data = s_readdata;
		s_chipselect = 1'b0;
		s_read = 1'b0;
	endtask

	task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
		@(negedge clk);
		s_chipselect = 1'b1;
		s_write = 1'b1;
		s_address = addr;
		s_writedata = data;
		@(negedge clk);
		s_chipselect = 1'b0;
		s_write = 1'b0;
	endtask

	// poll status until the writer has stored every message
	task automatic wait_for_count(input logic [7:0] want);
		logic [31:0] rd;
		rd = '0;
		while (rd[15:8] != want)
			read_reg(REG_STATUS, rd);
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial begin
		logic [31:0] rd;
		void'($urandom(32'had5f));
		reset_n = 1'b0;
		mode = 1'b0;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		s_write = 1'b0;
		s_address = '0;
		s_writedata = '0;
		sink_beat = '0;
		sink_valid = 1'b0;
		source_ready = 1'b0;
		repeat (2) @(negedge clk);
		reset_n = 1'b1;

		for (int f = 0; f < NUM_FRAMES; f++)
			send_packet(f);
		// source held from here, a stray extra beat stays in the output stage
		@(negedge clk);
		source_ready = 1'b0;

		// messages after video frames 1, 3 and 5
		wait_for_count(8'(exp_words.size()));
		for (int i = 0; i < 2 * MSG_WORDS; i++) begin
			read_reg(REG_MSG, rd);
			check_word("s_readdata", rd, exp_words.pop_front());
			read_reg(REG_STATUS, rd);
			check_count(rd[15:8], 8'(exp_words.size()));
		end
		read_reg(REG_ID, rd);
		check_word("s_readdata", rd, 32'h1234eee2);
		// flush drops the last message
		write_reg(REG_STATUS, 32'h0000_0010);
		read_reg(REG_STATUS, rd);
		check_count(rd[15:8], 8'd0);

		if (source_valid) begin
			$display("an extra output beat came after the last packet");
			stop_failed();
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

	`include "image_proc_tb_model.svh"

endmodule

`default_nettype wire
